// ==== rtl/x11_macros.svh ====
`ifndef X11_MACROS_SVH
`define X11_MACROS_SVH

// --------------------
// register map, low 20 bits of the bus address
// --------------------
`define X11_ADDR_CTRL        20'h00000  // global control
`define X11_ADDR_STATUS      20'h00004  // global status, read only
`define X11_ADDR_VERSION     20'h0000C  // version word, read only
`define X11_ADDR_SHA_CTRL    20'h00100  // sha-256 control
`define X11_ADDR_SHA_STATUS  20'h00104  // sha-256 fifo flags
`define X11_ADDR_SHA_PUSH    20'h0010C  // write pushes a word, read gives fill count
`define X11_ADDR_SHA_FILL    20'h00130  // fill count, read only

// --------------------
// word fifo geometry
// --------------------
`define X11_FIFO_DEPTH       16
`define X11_FIFO_AW          4          // log2 of depth

// build stamp, 0xYYMMDDss layout
`define X11_VERSION          32'h16081501

// --------------------
// control bit positions
// --------------------
`define X11_CTRL_ENABLE_BIT  0          // block enable in global ctrl
`define X11_SHA_ENABLE_BIT   0          // sha-256 enable
`define X11_SHA_RESET_BIT    1          // sha-256 reset, self clearing

`endif

// ==== rtl/x11_pkg.sv ====
`include "x11_macros.svh"

// shared types of the register block
package x11_pkg;

  // --------------------
  // bus side
  // --------------------

  // one bus data beat, also the width of every register
  typedef logic [31:0] bus_word_t;

  // decoded part of the address, upper bits ignored
  typedef logic [19:0] reg_addr_t;

  // --------------------
  // fifo side
  // --------------------

  // write pointer, wraps at the depth
  typedef logic [`X11_FIFO_AW-1:0] fifo_ptr_t;

  // fill count, one extra bit so a full fifo reads as 16
  typedef logic [`X11_FIFO_AW:0] fifo_cnt_t;

endpackage

// ==== rtl/x11_push_fifo.sv ====
`timescale 1ns/100ps
`include "x11_macros.svh"

module x11_push_fifo (
  input  logic               bus_clk,
  input  logic               bus_rstn,
  input  logic               push_valid_i,      // already gated by flush upstream
  input  x11_pkg::bus_word_t push_word_i,
  input  logic               fifo_flush_i,      // level, empties and holds
  output x11_pkg::fifo_cnt_t fill_count_o,
  output logic               fifo_empty_o,
  output logic               fifo_almost_full_o,
  output logic               fifo_full_o
);
  import x11_pkg::*;

  // word storage
  // only written here, the sha-256 consumer that drained it is gone
  // so the words wait for a future drain port
  bus_word_t mem [`X11_FIFO_DEPTH];

  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t wr_ptr_d;
  fifo_cnt_t count_q;
  fifo_cnt_t count_d;
  logic      empty_q;
  logic      almost_full_q;
  logic      full_q;
  logic      do_push;

  assign do_push = push_valid_i & ~full_q;   // full fifo drops the word

  // --------------------
  // next count and pointer
  // --------------------
  always_comb begin
    if (fifo_flush_i) begin
      count_d  = '0;
      wr_ptr_d = '0;
    end else begin
      count_d  = count_q + fifo_cnt_t'(do_push);
      wr_ptr_d = wr_ptr_q + fifo_ptr_t'(do_push);  // wraps at depth
    end
  end

  // count and flags move on the same edge
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      count_q       <= '0;
      wr_ptr_q      <= '0;
      empty_q       <= 1'b1;
      almost_full_q <= 1'b0;
      full_q        <= 1'b0;
    end else begin
      count_q       <= count_d;
      wr_ptr_q      <= wr_ptr_d;
      empty_q       <= (count_d == '0);
      almost_full_q <= (count_d >= fifo_cnt_t'(`X11_FIFO_DEPTH - 1));  // one slot left
      full_q        <= (count_d == fifo_cnt_t'(`X11_FIFO_DEPTH));
    end
  end

  // --------------------
  // storage write
  // --------------------
  always_ff @(posedge bus_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_word_i;
    end
  end

  assign fill_count_o       = count_q;
  assign fifo_empty_o       = empty_q;
  assign fifo_almost_full_o = almost_full_q;
  assign fifo_full_o        = full_q;

endmodule

// ==== rtl/x11_read_port.sv ====
`timescale 1ns/100ps
`include "x11_macros.svh"

module x11_read_port (
  input  logic               bus_clk,
  input  logic               bus_rstn,
  input  x11_pkg::reg_addr_t sys_addr_i,
  input  logic               sys_wen_i,
  input  logic               sys_ren_i,
  input  x11_pkg::bus_word_t ctrl_reg_i,
  input  x11_pkg::bus_word_t sha_ctrl_reg_i,
  input  logic               x11_enable_i,
  input  logic               sha_active_i,
  input  x11_pkg::fifo_cnt_t fill_count_i,
  input  logic               fifo_empty_i,
  input  logic               fifo_almost_full_i,
  input  logic               fifo_full_i,
  output x11_pkg::bus_word_t sys_rdata_o,
  output logic               sys_ack_o,
  output logic               sys_err_o
);
  import x11_pkg::*;

  bus_word_t status_word;
  bus_word_t sha_status_word;
  bus_word_t fill_word;
  bus_word_t rdata_d;
  bus_word_t rdata_q;       // only loaded on reads
  logic      ack_q;

  // --------------------
  // status assembly
  // --------------------
  assign status_word     = {27'b0, sha_active_i, 3'b0, x11_enable_i};       // bits 4 and 0
  assign sha_status_word = {25'b0, fifo_full_i, fifo_almost_full_i,
                            fifo_empty_i, 4'b0};                             // bits 6..4
  assign fill_word       = bus_word_t'(fill_count_i);                        // zero extend

  // read mux
  always_comb begin
    case (sys_addr_i)
      `X11_ADDR_CTRL:       rdata_d = ctrl_reg_i;
      `X11_ADDR_STATUS:     rdata_d = status_word;
      `X11_ADDR_VERSION:    rdata_d = `X11_VERSION;
      `X11_ADDR_SHA_CTRL:   rdata_d = sha_ctrl_reg_i;
      `X11_ADDR_SHA_STATUS: rdata_d = sha_status_word;
      `X11_ADDR_SHA_PUSH:   rdata_d = fill_word;   // push register reads back the count
      `X11_ADDR_SHA_FILL:   rdata_d = fill_word;
      default:              rdata_d = '0;          // unmapped reads zero
    endcase
  end

  // --------------------
  // bus response
  // --------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_wen_i | sys_ren_i;   // any strobe, any address
    end
  end

  always_ff @(posedge bus_clk) begin
    if (sys_ren_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign sys_err_o   = 1'b0;   // no access ever faults

endmodule

// ==== rtl/x11_reg_bank.sv ====
`timescale 1ns/100ps
`include "x11_macros.svh"

module x11_reg_bank (
  input  logic               bus_clk,
  input  logic               bus_rstn,
  input  x11_pkg::reg_addr_t sys_addr_i,      // low address from the bus
  input  x11_pkg::bus_word_t sys_wdata_i,
  input  logic               sys_wen_i,       // write strobe, one cycle
  output x11_pkg::bus_word_t ctrl_reg_o,
  output x11_pkg::bus_word_t sha_ctrl_reg_o,
  output logic               x11_enable_o,
  output logic               sha_active_o,
  output logic               push_valid_o,    // one cycle push strobe to the fifo
  output x11_pkg::bus_word_t push_word_o,
  output logic               fifo_flush_o     // level, holds the fifo empty
);
  import x11_pkg::*;

  bus_word_t ctrl_q;
  bus_word_t ctrl_d;
  bus_word_t sha_ctrl_q;
  bus_word_t sha_ctrl_d;
  bus_word_t push_word_q;       // payload, no reset
  logic      sha_active_q;
  logic      push_valid_q;
  logic      flush_q;
  logic      flush_d;
  logic      push_hit;

  // --------------------
  // write decode
  // --------------------
  always_comb begin
    ctrl_d     = ctrl_q;
    sha_ctrl_d = sha_ctrl_q;
    sha_ctrl_d[`X11_SHA_RESET_BIT] = 1'b0;   // reset bit lives one cycle only
    push_hit   = 1'b0;
    if (sys_wen_i) begin
      case (sys_addr_i)
        `X11_ADDR_CTRL:     ctrl_d     = sys_wdata_i;
        `X11_ADDR_SHA_CTRL: sha_ctrl_d = sys_wdata_i;  // a write may set the reset bit again
        `X11_ADDR_SHA_PUSH: push_hit   = 1'b1;
        default: begin
        end
      endcase
    end
  end

  // flush while the sha reset pulse is up or the whole block is off
  assign flush_d = sha_ctrl_d[`X11_SHA_RESET_BIT] | ~ctrl_d[`X11_CTRL_ENABLE_BIT];

  // --------------------
  // control state
  // --------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ctrl_q       <= '0;
      sha_ctrl_q   <= '0;
      sha_active_q <= 1'b0;
      push_valid_q <= 1'b0;
      flush_q      <= 1'b0;   // rises one cycle after reset, block still off
    end else begin
      ctrl_q       <= ctrl_d;
      sha_ctrl_q   <= sha_ctrl_d;
      sha_active_q <= sha_ctrl_d[`X11_SHA_ENABLE_BIT] & ctrl_d[`X11_CTRL_ENABLE_BIT];
      push_valid_q <= push_hit & ~flush_d;   // pushes into a flushed fifo are lost
      flush_q      <= flush_d;
    end
  end

  // push data, captured with the strobe
  always_ff @(posedge bus_clk) begin
    if (push_hit) begin
      push_word_q <= sys_wdata_i;
    end
  end

  assign ctrl_reg_o     = ctrl_q;
  assign sha_ctrl_reg_o = sha_ctrl_q;
  assign x11_enable_o   = ctrl_q[`X11_CTRL_ENABLE_BIT];
  assign sha_active_o   = sha_active_q;
  assign push_valid_o   = push_valid_q;
  assign push_word_o    = push_word_q;
  assign fifo_flush_o   = flush_q;

endmodule

// ==== rtl/x11_regs_top.sv ====
`timescale 1ns/100ps

module x11_regs_top (
  input  logic               bus_clk,
  input  logic               bus_rstn,
  input  x11_pkg::reg_addr_t sys_addr_i,
  input  x11_pkg::bus_word_t sys_wdata_i,
  input  logic               sys_wen_i,
  input  logic               sys_ren_i,
  output x11_pkg::bus_word_t sys_rdata_o,
  output logic               sys_ack_o,
  output logic               sys_err_o
);
  import x11_pkg::*;

  // --------------------
  // reg bank outputs
  // --------------------
  bus_word_t ctrl_reg;
  bus_word_t sha_ctrl_reg;
  logic      x11_enable;
  logic      sha_active;
  logic      push_valid;
  bus_word_t push_word;
  logic      fifo_flush;

  // fifo level
  fifo_cnt_t fill_count;
  logic      fifo_empty;
  logic      fifo_almost_full;
  logic      fifo_full;

  x11_reg_bank u_reg_bank (
    .bus_clk        (bus_clk),
    .bus_rstn       (bus_rstn),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .ctrl_reg_o     (ctrl_reg),
    .sha_ctrl_reg_o (sha_ctrl_reg),
    .x11_enable_o   (x11_enable),
    .sha_active_o   (sha_active),
    .push_valid_o   (push_valid),
    .push_word_o    (push_word),
    .fifo_flush_o   (fifo_flush)
  );

  x11_push_fifo u_push_fifo (
    .bus_clk            (bus_clk),
    .bus_rstn           (bus_rstn),
    .push_valid_i       (push_valid),
    .push_word_i        (push_word),
    .fifo_flush_i       (fifo_flush),
    .fill_count_o       (fill_count),
    .fifo_empty_o       (fifo_empty),
    .fifo_almost_full_o (fifo_almost_full),
    .fifo_full_o        (fifo_full)
  );

  x11_read_port u_read_port (
    .bus_clk            (bus_clk),
    .bus_rstn           (bus_rstn),
    .sys_addr_i         (sys_addr_i),
    .sys_wen_i          (sys_wen_i),
    .sys_ren_i          (sys_ren_i),
    .ctrl_reg_i         (ctrl_reg),
    .sha_ctrl_reg_i     (sha_ctrl_reg),
    .x11_enable_i       (x11_enable),
    .sha_active_i       (sha_active),
    .fill_count_i       (fill_count),
    .fifo_empty_i       (fifo_empty),
    .fifo_almost_full_i (fifo_almost_full),
    .fifo_full_i        (fifo_full),
    .sys_rdata_o        (sys_rdata_o),
    .sys_ack_o          (sys_ack_o),
    .sys_err_o          (sys_err_o)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_x11_regs -o tb_x11_regs \
  || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/tb_x11_regs)"
echo "$sim_out"
echo "$sim_out" | grep -qx "All tests passed" \
  && echo "simulation ok" \
  || { echo "simulation reported failure"; exit 1; }

// ==== tb/tb_x11_regs.sv ====
`timescale 1ns/100ps
`include "x11_macros.svh"

module tb_x11_regs;
  import x11_pkg::*;

  localparam int ACK_TIMEOUT = 20;   // cycles to wait for ack

  logic      bus_clk;
  logic      bus_rstn;
  reg_addr_t sys_addr;
  bus_word_t sys_wdata;
  logic      sys_wen;
  logic      sys_ren;
  bus_word_t sys_rdata;
  logic      sys_ack;
  logic      sys_err;

  int        error_count;
  int        check_count;
  int        model_count;   // expected fifo fill
  logic      model_on;      // block enabled, fifo not flushed

  x11_regs_top x11_regs_top_i (
    .bus_clk     (bus_clk),
    .bus_rstn    (bus_rstn),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err)
  );

  always #10 bus_clk = ~bus_clk;   // 20 ns period

  // --------------------
  // compare and bus tasks
  // --------------------
  task automatic check_equal(input bus_word_t actual, input bus_word_t expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s read %08h, expected %08h", $time, what, actual, expected);
    end
  endtask

  // ack is registered, so it shows at the falling edge after the strobe
  task automatic wait_ack();
    int cycles;
    cycles = 0;
    while (sys_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
      @(negedge bus_clk);
      cycles++;
    end
    if (sys_ack !== 1'b1) begin
      $display("Bus acknowledge did not arrive within %0d cycles at %0t", ACK_TIMEOUT, $time);
      $display("Some tests failed");
      $finish;
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input bus_word_t data);
    @(negedge bus_clk);
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = 1'b1;   // one cycle strobe
    @(negedge bus_clk);
    sys_wen   = 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input reg_addr_t addr, output bus_word_t data);
    @(negedge bus_clk);
    sys_addr = addr;
    sys_ren  = 1'b1;
    @(negedge bus_clk);
    sys_ren  = 1'b0;
    wait_ack();
    data = sys_rdata;   // valid with ack
    check_equal(bus_word_t'(sys_err), '0, "bus error flag");
  endtask

  task automatic check_read(input reg_addr_t addr, input bus_word_t expected, input string what);
    bus_word_t data;
    bus_read(addr, data);
    check_equal(data, expected, what);
  endtask

  // count lands two edges after the push strobe
  task automatic idle_cycles(input int n);
    repeat (n) @(negedge bus_clk);
  endtask

  // sha status bits 4, 5, 6 from a fill level
  function automatic bus_word_t sha_status_expect(input int count);
    bus_word_t word;
    word    = '0;
    word[4] = (count == 0);                    // empty
    word[5] = (count >= `X11_FIFO_DEPTH - 1);  // almost full
    word[6] = (count == `X11_FIFO_DEPTH);      // full
    return word;
  endfunction

  task automatic push_words(input int n);
    for (int i = 0; i < n; i++) begin
      bus_write(`X11_ADDR_SHA_PUSH, 32'hA5000000 + i);
      if (model_on && model_count < `X11_FIFO_DEPTH) model_count++;   // drop when full
    end
    idle_cycles(2);
  endtask

  task automatic check_fill(input string what);
    check_read(`X11_ADDR_SHA_PUSH, bus_word_t'(model_count), {what, " count at push reg"});
    check_read(`X11_ADDR_SHA_FILL, bus_word_t'(model_count), {what, " count at fill reg"});
    check_read(`X11_ADDR_SHA_STATUS, sha_status_expect(model_count), {what, " sha status"});
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_reset_values();
    check_read(`X11_ADDR_CTRL, 32'h0, "ctrl after reset");
    check_read(`X11_ADDR_STATUS, 32'h0, "status after reset");
    check_read(`X11_ADDR_SHA_CTRL, 32'h0, "sha ctrl after reset");
    check_read(`X11_ADDR_VERSION, `X11_VERSION, "version");
    check_read(20'h00200, 32'h0, "unmapped address");
    check_fill("after reset");   // empty flag only
  endtask

  task automatic test_enable_readback();
    bus_write(`X11_ADDR_CTRL, 32'h1);
    bus_write(`X11_ADDR_SHA_CTRL, 32'h1);
    model_on = 1'b1;
    check_read(`X11_ADDR_CTRL, 32'h1, "ctrl readback");
    check_read(`X11_ADDR_SHA_CTRL, 32'h1, "sha ctrl readback");
    check_read(`X11_ADDR_STATUS, 32'h11, "status enabled");   // enable and sha active
  endtask

  task automatic test_push_count();
    for (int n = 1; n <= 5; n++) begin
      push_words(1);
      check_fill("single push");
    end
  endtask

  task automatic test_fill_to_full();
    push_words(20 - model_count);   // twenty pushes in total
    check_fill("overfilled");
    check_read(`X11_ADDR_SHA_FILL, 32'd16, "fill saturates at depth");
  endtask

  task automatic test_flush();
    bus_write(`X11_ADDR_SHA_CTRL, 32'h3);   // enable plus reset
    model_count = 0;
    idle_cycles(2);
    check_read(`X11_ADDR_SHA_CTRL, 32'h1, "sha reset self clears");
    check_fill("after sha reset");
    push_words(3);
    check_fill("refill");
    bus_write(`X11_ADDR_CTRL, 32'h0);       // block off holds fifo empty
    model_on    = 1'b0;
    model_count = 0;
    idle_cycles(2);
    check_fill("block disabled");
    push_words(4);
    check_fill("push while disabled");
    check_read(`X11_ADDR_STATUS, 32'h0, "status disabled");
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    bus_clk     = 1'b0;
    bus_rstn    = 1'b0;
    sys_addr    = '0;
    sys_wdata   = '0;
    sys_wen     = 1'b0;
    sys_ren     = 1'b0;
    error_count = 0;
    check_count = 0;
    model_count = 0;
    model_on    = 1'b0;
    repeat (16) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rstn = 1'b1;

    test_reset_values();
    test_enable_readback();
    test_push_count();
    test_fill_to_full();
    test_flush();

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/x11_regs_props.sv ====
`timescale 1ns/100ps
`include "x11_macros.svh"

module x11_regs_props (
  input logic               bus_clk,
  input logic               bus_rstn,
  input logic               sys_wen_i,
  input logic               sys_ren_i,
  input logic               sys_ack_i,
  input logic               sys_err_i,
  input x11_pkg::fifo_cnt_t fill_count_i
);
  import x11_pkg::*;

  // --------------------
  // bus handshake
  // --------------------
  ack_follows_strobe: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    (sys_wen_i || sys_ren_i) |=> sys_ack_i)
    else $error("ack missing one cycle after strobe");

  err_never_high: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    !sys_err_i)
    else $error("bus error raised");

  // fifo level bound
  fill_within_depth: assert property (@(posedge bus_clk) disable iff (!bus_rstn)
    fill_count_i <= fifo_cnt_t'(`X11_FIFO_DEPTH))
    else $error("fill count above depth");

endmodule

bind x11_regs_top x11_regs_props u_regs_props (
  .bus_clk      (bus_clk),
  .bus_rstn     (bus_rstn),
  .sys_wen_i    (sys_wen_i),
  .sys_ren_i    (sys_ren_i),
  .sys_ack_i    (sys_ack_o),
  .sys_err_i    (sys_err_o),
  .fill_count_i (fill_count)
);

// ==== vlog.f ====
+incdir+rtl
rtl/x11_pkg.sv
rtl/x11_reg_bank.sv
rtl/x11_push_fifo.sv
rtl/x11_read_port.sv
rtl/x11_regs_top.sv
tb/x11_regs_props.sv
tb/tb_x11_regs.sv
